// File: flist.f
+incdir+verilog
verilog/eth_stats_pkg.sv
verilog/eth_stats_control.sv
verilog/eth_frame_meter.sv
verilog/eth_stats_accumulator.sv
verilog/eth_stats_log.sv
verilog/eth_stats_top.sv
test/eth_stats_checker.sv
test/eth_stats_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the statistics collector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module eth_stats_tb -o eth_stats_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/eth_stats_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// File: test/eth_stats_tb.sv
////////////////////
// Statistics collector testbench
// Random frames, register accesses and log back-pressure
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_stats_defines.svh"

module eth_stats_tb;
	// Phase lengths plus drains and register reads
	localparam int TEST_CYCLES = 600 + 300 + 300 + 1500 + 200 + 800 + 300 + 600;
	localparam int LIMIT = 2 * TEST_CYCLES;
	localparam logic [15:0] LOG_ID = 16'h5ac3;

	logic clk;
	logic reset;
	eth_stats_pkg::stream_tap_t tx_tap;
	eth_stats_pkg::stream_tap_t rx_tap;
	logic [63:0] current_time;
	logic time_running;
	logic reg_wr;
	logic reg_rd;
	logic [3:0] reg_addr;
	logic [31:0] reg_wdata;
	logic [31:0] reg_rdata;
	logic reg_rvalid;
	logic [63:0] log_data;
	logic log_last;
	logic log_valid;
	logic log_ready;
	logic overflow_expected;
	logic stall;
	logic [31:0] lfsr;
	int rem[2];
	logic user_bit[2];
	int cycle_count;
	int errors;
	int checker_errors;

	eth_stats_top eth_stats_top_i (
		.clk(clk),
		.reset(reset),
		.tx_tap(tx_tap),
		.rx_tap(rx_tap),
		.current_time(current_time),
		.time_running(time_running),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.log_data(log_data),
		.log_last(log_last),
		.log_valid(log_valid),
		.log_ready(log_ready)
	);

	eth_stats_checker checker_i (
		.clk(clk),
		.reset(reset),
		.tx_tap(tx_tap),
		.rx_tap(rx_tap),
		.current_time(current_time),
		.time_running(time_running),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.log_data(log_data),
		.log_last(log_last),
		.log_valid(log_valid),
		.log_ready(log_ready),
		.overflow_expected(overflow_expected),
		.error_count(checker_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= LIMIT) begin
			$display("Timeout after %0d cycles, error count %0d", cycle_count,
				errors + checker_errors);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic next_tap(input int d, input bit allow,
		input eth_stats_pkg::stream_tap_t cur, output eth_stats_pkg::stream_tap_t nxt);
		logic [31:0] r;
		logic accepted;
		accepted = cur.valid && cur.ready;
		nxt = cur;
		if (accepted)
			rem[d]--;
		if (rem[d] == 0 && allow) begin
			take_bits(6, r);
			rem[d] = int'(r[5:0]) + 1;
			take_bits(2, r);
			user_bit[d] = (r[1:0] == 2'd0);
		end
		if (rem[d] == 0) begin
			nxt.valid = 1'b0;
		end else if (cur.valid && !accepted) begin
			nxt.valid = 1'b1;
		end else begin
			take_bits(2, r);
			nxt.valid = (r[1:0] != 2'd0);
		end
		nxt.last = (rem[d] == 1);
		nxt.user = (rem[d] == 1) && user_bit[d];
		take_bits(2, r);
		nxt.ready = (d == 0) || (r[1:0] != 2'd0);
	endtask

	// One clock of stimulus with new frames started only when allow is set
	task automatic tick(input bit allow);
		eth_stats_pkg::stream_tap_t t;
		logic [31:0] r;
		@(posedge clk);
		next_tap(0, allow, tx_tap, t);
		tx_tap <= t;
		next_tap(1, allow, rx_tap, t);
		rx_tap <= t;
		take_bits(5, r);
		log_ready <= stall ? (r[4:0] == 5'd0) : (r[1:0] != 2'd0);
		current_time <= current_time + 64'd1;
		reg_wr <= 1'b0;
		reg_rd <= 1'b0;
	endtask

	task automatic run_traffic(input int n);
		repeat (n) tick(1'b1);
		while (rem[0] != 0 || rem[1] != 0)
			tick(1'b0);
		repeat (8) tick(1'b0);
	endtask

	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		tick(1'b0);
		reg_wr <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		tick(1'b0);
	endtask

	task automatic reg_read(input logic [3:0] addr);
		int n;
		n = 0;
		tick(1'b0);
		reg_rd <= 1'b1;
		reg_addr <= addr;
		tick(1'b0);
		tick(1'b0);
		while (!reg_rvalid && n < 4) begin
			tick(1'b0);
			n++;
		end
		if (!reg_rvalid) begin
			$display("No read response for register %0d", addr);
			errors++;
		end
	endtask

	task automatic read_stats();
		for (int a = 4; a < 16; a++)
			reg_read(4'(a));
	endtask

	function automatic logic [31:0] ctrl_word(input logic en, input logic clr, input logic log);
		return {LOG_ID, 13'd0, log, clr, en};
	endfunction

	initial begin
		reset = 1'b1;
		tx_tap = '0;
		rx_tap = '0;
		current_time = '0;
		time_running = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		log_ready = 1'b0;
		overflow_expected = 1'b0;
		stall = 1'b0;
		lfsr = 32'h85b2e427;
		rem[0] = 0;
		rem[1] = 0;
		user_bit[0] = 1'b0;
		user_bit[1] = 1'b0;
		cycle_count = 0;
		errors = 0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// Counting with enable set
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
		run_traffic(600);
		read_stats();
		reg_read(`ETH_REG_OVERFLOW);

		// Disabled and then with the time base stopped
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0));
		run_traffic(300);
		read_stats();
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
		time_running <= 1'b0;
		run_traffic(300);
		read_stats();
		time_running <= 1'b1;

		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b0));
		repeat (4) tick(1'b0);
		read_stats();
		reg_read(`ETH_REG_OVERFLOW);

		// Log records with mild back-pressure
		reg_write(`ETH_REG_PERIOD, 32'd40);
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1));
		run_traffic(1500);
		repeat (200) tick(1'b0);
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
		while (log_valid)
			tick(1'b0);
		read_stats();

		// Long stalls with a short period force overflows
		stall = 1'b1;
		overflow_expected <= 1'b1;
		reg_write(`ETH_REG_PERIOD, 32'd20);
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1));
		run_traffic(800);
		reg_read(`ETH_REG_OVERFLOW);
		stall = 1'b0;
		repeat (300) tick(1'b0);
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
		while (log_valid)
			tick(1'b0);
		overflow_expected <= 1'b0;
		reg_read(`ETH_REG_OVERFLOW);
		read_stats();

		// Clear once overflows have been counted
		reg_write(`ETH_REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b0));
		repeat (4) tick(1'b0);
		reg_read(`ETH_REG_OVERFLOW);
		read_stats();

		$display("Error count: %0d", errors + checker_errors);
		if (errors + checker_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: test/eth_stats_checker.sv
////////////////////
// Statistics checker
// Totals model, register read and log record checks
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_stats_defines.svh"

module eth_stats_checker (
	input wire logic clk,
	input wire logic reset,
	input wire eth_stats_pkg::stream_tap_t tx_tap,
	input wire eth_stats_pkg::stream_tap_t rx_tap,
	input wire logic [63:0] current_time,
	input wire logic time_running,
	input wire logic reg_wr,
	input wire logic reg_rd,
	input wire logic [3:0] reg_addr,
	input wire logic [31:0] reg_wdata,
	input wire logic [31:0] reg_rdata,
	input wire logic reg_rvalid,
	input wire logic [63:0] log_data,
	input wire logic log_last,
	input wire logic log_valid,
	input wire logic log_ready,
	input wire logic overflow_expected,
	output int error_count
);
	// Totals in order tx bytes, good, bad, then rx bytes, good, bad
	logic [63:0] tot[6];
	logic [63:0] prev[6];
	logic [63:0] snap_exp[6];
	logic [63:0] rec[8];
	int len[2];
	logic m_enable;
	logic [15:0] m_log_id;
	logic [31:0] min_period;
	int valid_cycles;
	int records;
	int idle;
	int word_cnt;
	int stall_recs;
	logic rec_exact;
	logic prev_valid;
	logic held;
	logic [63:0] held_data;
	logic held_last;
	logic rd_pend;
	logic [3:0] rd_addr;
	logic [31:0] rd_exp;
	logic [63:0] prev_time;
	logic [63:0] snap_time;

	task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
		error_count++;
	endtask

	task automatic fault(input string msg);
		$display("At %0t: %s", $time, msg);
		error_count++;
	endtask

	// Triggers that could land on a busy log block
	function automatic logic [63:0] ovf_bound();
		return 64'(valid_cycles) / (64'(min_period) + 64'd1) + 64'(records);
	endfunction

	task automatic meter(input int d, input eth_stats_pkg::stream_tap_t t);
		if (t.valid && t.ready) begin
			idle = 0;
			len[d]++;
			if (t.last) begin
				if (m_enable && time_running) begin
					tot[3*d] = tot[3*d] + 64'(len[d]);
					if (t.user)
						tot[3*d+2] = tot[3*d+2] + 64'd1;
					else
						tot[3*d+1] = tot[3*d+1] + 64'd1;
				end
				len[d] = 0;
			end
		end
	endtask

	task automatic check_record();
		if (rec[0][63:48] != m_log_id)
			value_error("log_data word 0 log_id", 64'(rec[0][63:48]), 64'(m_log_id));
		if (rec[0][47:32] != 16'd0)
			value_error("log_data word 0 reserved", 64'(rec[0][47:32]), 64'd0);
		if (64'(rec[0][31:0]) > ovf_bound())
			fault("Record overflow count above the possible number of triggers");
		if (overflow_expected) begin
			if (stall_recs > 0 && rec[0][31:0] == 32'd0)
				fault("Record after a stalled record reports no overflow");
			stall_recs++;
		end else begin
			stall_recs = 0;
		end
		if (rec[1] != snap_time)
			value_error("log_data word 1", rec[1], snap_time);
		for (int i = 0; i < 6; i++) begin
			if (rec[i+2] < prev[i])
				fault($sformatf("Record word %0d went down since the last record", i + 2));
			if (rec[i+2] > tot[i])
				fault($sformatf("Record word %0d exceeds the model total", i + 2));
			if (rec_exact && rec[i+2] != snap_exp[i])
				value_error($sformatf("log_data word %0d", i + 2), rec[i+2], snap_exp[i]);
			prev[i] = rec[i+2];
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			tot = '{default: '0};
			prev = '{default: '0};
			len = '{default: 0};
			m_enable = 1'b0;
			m_log_id = '0;
			min_period = '1;
			valid_cycles = 0;
			records = 0;
			idle = 0;
			word_cnt = 0;
			stall_recs = 0;
			rec_exact = 1'b0;
			prev_valid = 1'b0;
			held = 1'b0;
			rd_pend = 1'b0;
			prev_time = '0;
			snap_time = '0;
			error_count = 0;
		end else begin
			if (reg_rvalid) begin
				if (!rd_pend) begin
					fault("Read response without a request");
				end else if (rd_addr == `ETH_REG_OVERFLOW) begin
					if (valid_cycles == 0 && reg_rdata != 32'd0)
						value_error("overflow_count", 64'(reg_rdata), 64'd0);
					else if (64'(reg_rdata) > ovf_bound())
						fault("Overflow register above the possible number of triggers");
					if (overflow_expected && reg_rdata == 32'd0)
						fault("No overflow reported after stalled records");
				end else if (rd_addr >= `ETH_REG_STATS_BASE && reg_rdata != rd_exp) begin
					value_error($sformatf("reg_rdata at %0d", rd_addr), 64'(reg_rdata),
						64'(rd_exp));
				end
				rd_pend = 1'b0;
			end
			if (reg_rd) begin
				rd_pend = 1'b1;
				rd_addr = reg_addr;
				rd_exp = '0;
				if (reg_addr >= `ETH_REG_STATS_BASE) begin
					logic [3:0] k;
					k = reg_addr - `ETH_REG_STATS_BASE;
					rd_exp = k[0] ? tot[k[3:1]][63:32] : tot[k[3:1]][31:0];
				end
			end
			if (reg_wr && reg_addr == `ETH_REG_CTRL) begin
				m_enable = reg_wdata[0];
				m_log_id = reg_wdata[31:16];
				if (reg_wdata[1]) begin
					tot = '{default: '0};
					prev = '{default: '0};
					valid_cycles = 0;
					records = 0;
					idle = 0;
				end
			end
			if (reg_wr && reg_addr == `ETH_REG_PERIOD && reg_wdata < min_period)
				min_period = reg_wdata;

			idle++;
			meter(0, tx_tap);
			meter(1, rx_tap);

			if (held) begin
				if (!log_valid)
					fault("log_valid dropped before the word was accepted");
				if (log_data != held_data)
					value_error("log_data", log_data, held_data);
				if (log_last != held_last)
					value_error("log_last", 64'(log_last), 64'(held_last));
			end
			if (log_valid)
				valid_cycles++;
			// Snapshot for a new record was taken at the previous edge
			if (log_valid && !prev_valid) begin
				if (word_cnt != 0)
					fault($sformatf("Record ended after %0d words", word_cnt));
				records++;
				rec_exact = (idle >= 5);
				snap_exp = tot;
				snap_time = prev_time;
				word_cnt = 0;
			end
			if (log_valid && log_ready && word_cnt < 8) begin
				rec[word_cnt] = log_data;
				if (log_last != (word_cnt == 7))
					value_error("log_last", 64'(log_last), 64'(word_cnt == 7));
				if (word_cnt == 7) begin
					check_record();
					word_cnt = 0;
				end else begin
					word_cnt++;
				end
			end
			held = log_valid && !log_ready;
			held_data = log_data;
			held_last = log_last;
			prev_valid = log_valid;
			prev_time = current_time;
		end
	end
endmodule

`default_nettype wire

// File: verilog/eth_stats_top.sv
////////////////////
// Ethernet statistics collector top
// Meters and totals for tx and rx, register port and log stream
////////////////////

`timescale 1ns/1ps
`default_nettype none

module eth_stats_top (
	input wire logic clk,
	input wire logic reset,

	input wire eth_stats_pkg::stream_tap_t tx_tap,
	input wire eth_stats_pkg::stream_tap_t rx_tap,

	input wire logic [63:0] current_time,
	input wire logic time_running,

	input wire logic reg_wr,
	input wire logic reg_rd,
	input wire logic [3:0] reg_addr,
	input wire logic [31:0] reg_wdata,
	output logic [31:0] reg_rdata,
	output logic reg_rvalid,

	output logic [63:0] log_data,
	output logic log_last,
	output logic log_valid,
	input wire logic log_ready
);
	eth_stats_pkg::stats_ctrl_t ctrl;
	eth_stats_pkg::frame_summary_t tx_summary;
	eth_stats_pkg::frame_summary_t rx_summary;
	eth_stats_pkg::stats_totals_t tx_totals;
	eth_stats_pkg::stats_totals_t rx_totals;
	logic trigger;
	logic log_busy;
	logic [31:0] overflow_count;

	eth_stats_control control_i (
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.reg_rd(reg_rd),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.reg_rvalid(reg_rvalid),
		.tx_totals(tx_totals),
		.rx_totals(rx_totals),
		.log_busy(log_busy),
		.time_running(time_running),
		.ctrl(ctrl),
		.trigger(trigger),
		.overflow_count(overflow_count)
	);

	// Transmit direction
	eth_frame_meter tx_meter_i (
		.clk(clk),
		.reset(reset),
		.tap(tx_tap),
		.summary(tx_summary)
	);

	eth_stats_accumulator tx_accum_i (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.summary(tx_summary),
		.totals(tx_totals)
	);

	// Receive direction
	eth_frame_meter rx_meter_i (
		.clk(clk),
		.reset(reset),
		.tap(rx_tap),
		.summary(rx_summary)
	);

	eth_stats_accumulator rx_accum_i (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.summary(rx_summary),
		.totals(rx_totals)
	);

	eth_stats_log log_i (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.trigger(trigger),
		.current_time(current_time),
		.overflow_count(overflow_count),
		.tx_totals(tx_totals),
		.rx_totals(rx_totals),
		.log_data(log_data),
		.log_last(log_last),
		.log_valid(log_valid),
		.log_ready(log_ready),
		.log_busy(log_busy)
	);
endmodule

`default_nettype wire

// File: verilog/eth_stats_log.sv
////////////////////
// Statistics log
// Snapshot on trigger, sent as an 8-word record
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_stats_defines.svh"

module eth_stats_log (
	input wire logic clk,
	input wire logic reset,
	input wire eth_stats_pkg::stats_ctrl_t ctrl,
	input wire logic trigger,
	input wire logic [63:0] current_time,
	input wire logic [31:0] overflow_count,
	input wire eth_stats_pkg::stats_totals_t tx_totals,
	input wire eth_stats_pkg::stats_totals_t rx_totals,

	output logic [63:0] log_data,
	output logic log_last,
	output logic log_valid,
	input wire logic log_ready,
	output logic log_busy
);
	localparam int IDX_W = $clog2(`ETH_LOG_WORDS);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`ETH_LOG_WORDS - 1);

	logic busy;
	logic start;
	logic [IDX_W-1:0] word_idx;
	logic [63:0] snap [`ETH_LOG_WORDS];

	// A trigger during a record is dropped here and counted upstream
	assign start = trigger && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			word_idx <= '0;
		end else if (start) begin
			busy <= 1'b1;
			word_idx <= '0;
		end else if (busy && log_ready) begin
			if (word_idx == LAST_IDX)
				busy <= 1'b0;
			else
				word_idx <= word_idx + 1'b1;
		end
	end

	// Snapshot of all counters at the trigger
	always_ff @(posedge clk) begin
		if (start) begin
			snap[0] <= {ctrl.log_id, 16'd0, overflow_count};
			snap[1] <= current_time;
			snap[2] <= tx_totals.bytes;
			snap[3] <= tx_totals.good;
			snap[4] <= tx_totals.bad;
			snap[5] <= rx_totals.bytes;
			snap[6] <= rx_totals.good;
			snap[7] <= rx_totals.bad;
		end
	end

	// Word index only moves on an accepted word, so data holds under stall
	assign log_data = snap[word_idx];
	assign log_valid = busy;
	assign log_last = busy && (word_idx == LAST_IDX);
	assign log_busy = busy;
endmodule

`default_nettype wire

// File: verilog/eth_stats_accumulator.sv
////////////////////
// Statistics accumulator
// 64-bit byte, good and bad frame totals
////////////////////

`timescale 1ns/1ps
`default_nettype none

module eth_stats_accumulator (
	input wire logic clk,
	input wire logic reset,
	input wire eth_stats_pkg::stats_ctrl_t ctrl,
	input wire eth_stats_pkg::frame_summary_t summary,
	output eth_stats_pkg::stats_totals_t totals
);
	always_ff @(posedge clk) begin
		if (reset || ctrl.clear) begin
			totals <= '0;
		end else if (ctrl.enable && summary.valid) begin
			totals.bytes <= totals.bytes + 64'(summary.length);
			if (summary.good)
				totals.good <= totals.good + 64'd1;
			else
				totals.bad <= totals.bad + 64'd1;
		end
	end
endmodule

`default_nettype wire

// File: verilog/eth_frame_meter.sv
////////////////////
// Frame meter
// Length and status of each frame on one tap
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_stats_defines.svh"

module eth_frame_meter (
	input wire logic clk,
	input wire logic reset,
	input wire eth_stats_pkg::stream_tap_t tap,
	output eth_stats_pkg::frame_summary_t summary
);
	logic beat;
	logic [`ETH_FRAME_LEN_W-1:0] count;
	logic [`ETH_FRAME_LEN_W-1:0] next_count;
	logic sum_valid;
	logic sum_good;
	logic [`ETH_FRAME_LEN_W-1:0] sum_length;

	assign beat = tap.valid && tap.ready;
	// Saturate rather than wrap on jumbo garbage
	assign next_count = (&count) ? count : count + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			sum_valid <= 1'b0;
		end else begin
			sum_valid <= beat && tap.last;
			if (beat)
				count <= tap.last ? '0 : next_count;
		end
	end

	always_ff @(posedge clk) begin
		if (beat && tap.last) begin
			sum_length <= next_count;
			sum_good <= ~tap.user;
		end
	end

	always_comb begin
		summary.valid = sum_valid;
		summary.length = sum_length;
		summary.good = sum_good;
	end
endmodule

`default_nettype wire

// File: verilog/eth_stats_control.sv
////////////////////
// Statistics control block
// Registers, sample timer, log trigger and overflow count
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "eth_stats_defines.svh"

module eth_stats_control (
	input wire logic clk,
	input wire logic reset,

	input wire logic reg_wr,
	input wire logic reg_rd,
	input wire logic [3:0] reg_addr,
	input wire logic [31:0] reg_wdata,
	output logic [31:0] reg_rdata,
	output logic reg_rvalid,

	input wire eth_stats_pkg::stats_totals_t tx_totals,
	input wire eth_stats_pkg::stats_totals_t rx_totals,
	input wire logic log_busy,
	input wire logic time_running,

	output eth_stats_pkg::stats_ctrl_t ctrl,
	output logic trigger,
	output logic [31:0] overflow_count
);
	logic enable;
	logic log_enable;
	logic clear_pulse;
	logic [15:0] log_id;
	logic [31:0] period;
	logic [31:0] sample_timer;
	logic [383:0] stats_words;
	logic [3:0] stats_idx;
	logic ctrl_wr;

	assign ctrl_wr = reg_wr && (reg_addr == `ETH_REG_CTRL);

	always_ff @(posedge clk) begin
		if (reset) begin
			enable <= 1'b0;
			log_enable <= 1'b0;
			log_id <= '0;
			period <= '1;
			clear_pulse <= 1'b0;
		end else begin
			// Clear is self-clearing, only high the cycle after the write
			clear_pulse <= ctrl_wr && reg_wdata[1];
			if (ctrl_wr) begin
				enable <= reg_wdata[0];
				log_enable <= reg_wdata[2];
				log_id <= reg_wdata[31:16];
			end
			if (reg_wr && (reg_addr == `ETH_REG_PERIOD))
				period <= reg_wdata;
		end
	end

	// Accumulators see enable already qualified by the time base
	always_comb begin
		ctrl.enable = enable && time_running;
		ctrl.log_enable = log_enable;
		ctrl.clear = clear_pulse;
		ctrl.log_id = log_id;
	end

	// Sample timer restarts after reaching the period
	always_ff @(posedge clk) begin
		if (reset || clear_pulse) begin
			sample_timer <= '0;
			trigger <= 1'b0;
		end else if (sample_timer >= period) begin
			sample_timer <= '0;
			trigger <= log_enable;
		end else begin
			sample_timer <= sample_timer + 32'd1;
			trigger <= 1'b0;
		end
	end

	// Triggers that land on a busy log block are lost
	always_ff @(posedge clk) begin
		if (reset || clear_pulse)
			overflow_count <= '0;
		else if (trigger && log_busy)
			overflow_count <= overflow_count + 32'd1;
	end

	// Stats halves in register order, tx_bytes low half at index 0
	assign stats_words = {rx_totals.bad, rx_totals.good, rx_totals.bytes,
		tx_totals.bad, tx_totals.good, tx_totals.bytes};
	assign stats_idx = reg_addr - `ETH_REG_STATS_BASE;

	always_ff @(posedge clk) begin
		if (reset)
			reg_rvalid <= 1'b0;
		else
			reg_rvalid <= reg_rd;
	end

	always_ff @(posedge clk) begin
		if (reg_rd) begin
			case (reg_addr)
				`ETH_REG_CTRL:
					reg_rdata <= {log_id, 13'd0, log_enable, 1'b0, enable};
				`ETH_REG_PERIOD:
					reg_rdata <= period;
				`ETH_REG_OVERFLOW:
					reg_rdata <= overflow_count;
				default: begin
					if (reg_addr >= `ETH_REG_STATS_BASE)
						reg_rdata <= stats_words[stats_idx * 32 +: 32];
					else
						reg_rdata <= '0;
				end
			endcase
		end
	end
endmodule

`default_nettype wire

// File: verilog/eth_stats_pkg.sv
////////////////////
// Ethernet statistics package
// Tap, summary, totals and control types
////////////////////

`default_nettype none

`include "eth_stats_defines.svh"

package eth_stats_pkg;

	// Monitored stream signals, beat when valid & ready
	typedef struct packed {
		logic valid;
		logic ready;
		logic last;
		logic user;
	} stream_tap_t;

	// One finished frame
	typedef struct packed {
		logic valid;
		logic [`ETH_FRAME_LEN_W-1:0] length;
		logic good;
	} frame_summary_t;

	// Running totals for one direction
	typedef struct packed {
		logic [63:0] bytes;
		logic [63:0] good;
		logic [63:0] bad;
	} stats_totals_t;

	typedef struct packed {
		logic enable;
		logic log_enable;
		logic clear;
		logic [15:0] log_id;
	} stats_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/eth_stats_defines.svh
////////////////////
// Ethernet statistics collector
// Register map, frame length width and log record size
////////////////////

`ifndef ETH_STATS_DEFINES_SVH
`define ETH_STATS_DEFINES_SVH

// Width of the per-frame length field
`define ETH_FRAME_LEN_W 17

// 64-bit words in one log record
`define ETH_LOG_WORDS 8

// Register addresses
`define ETH_REG_CTRL 4'd0
`define ETH_REG_PERIOD 4'd1
`define ETH_REG_OVERFLOW 4'd2
// Stats halves live at 4 to 15, low half first
`define ETH_REG_STATS_BASE 4'd4

`endif
